//--- list.f
tree_route_pkg.sv
tree_nca_route.sv
tree_next_router_addr.sv
tree_lookahead_route.sv
tree_destport_gen.sv
tree_route_unit.sv
tree_route_assertions.sv
tb_tree_route_unit.sv

//--- Bender.yml
package:
  name: tree_route_unit

sources:
  - tree_route_pkg.sv
  - tree_nca_route.sv
  - tree_next_router_addr.sv
  - tree_lookahead_route.sv
  - tree_destport_gen.sv
  - tree_route_unit.sv
  - target: simulation
    files:
      - tree_route_assertions.sv
      - tb_tree_route_unit.sv

//--- tb_tree_route_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tree_route_unit;
    import tree_route_pkg::*;

    localparam int N_DIR        = 10;
    localparam int N_RAND       = 200;
    localparam int N_ROWS       = N_DIR + N_RAND;
    localparam int RESET_CYCLES = 16;

    typedef struct packed {
        router_pos_t pos;
        route_req_t  req;
        logic [1:0]  gap;                            // idle cycles after the request
    } row_t;

    typedef struct packed {
        route_rsp_t  rsp;
        logic [31:0] due;                            // cycle the response belongs to
    } exp_t;

    logic        clk = 1'b0;
    logic        rst;
    router_pos_t pos;
    logic        req_valid;
    route_req_t  req;
    logic        rsp_valid;
    route_rsp_t  rsp;

    row_t        table_rows [N_ROWS];
    int          n_rows;
    exp_t        exp_q [$];
    int          cycle;
    int          cycle_limit;
    int          errors;
    int          checks;
    logic        last_valid;
    router_pos_t last_pos;

    always #2 clk = ~clk;

    tree_route_unit tree_route_unit_i (.*);

    bind tree_route_unit tree_route_assertions assertions_i (.*);

    // ======================================================================
    // reference model
    // ======================================================================
    function automatic int digit_of(input tree_addr_t a, input int i);
        return int'((a >> (i * KW)) & ((1 << KW) - 1));
    endfunction

    function automatic tree_addr_t set_digit(input tree_addr_t a, input int i, input int v);
        tree_addr_t m;
        m = tree_addr_t'(((1 << KW) - 1) << (i * KW));
        return (a & ~m) | (tree_addr_t'(v << (i * KW)) & m);
    endfunction

    // up on an ancestor mismatch, else the dest digit at level lv
    function automatic int route_port(input tree_addr_t a, input int lv, input tree_addr_t d);
        for (int i = lv + 1; i < TREE_L; i++) begin
            if (digit_of(a, i - 1) != digit_of(d, i))
                return UP_PORT;
        end
        return digit_of(d, lv);
    endfunction

    function automatic route_rsp_t model_rsp(input row_t r);
        int              lv;
        int              cur;
        int              inp;
        int              k;
        tree_addr_t      na;
        logic [TREE_K:0] oh;
        route_rsp_t      e;
        lv  = int'(r.pos.level);
        cur = int'(r.req.cur_port);
        inp = int'(r.req.in_port);
        e   = '0;
        if (cur == UP_PORT) begin
            na        = set_digit(r.pos.addr, lv - 1, 0);   // parent
            e.lk_port = tree_port_e'(route_port(na, lv - 1, r.req.dest_addr));
        end else if (lv + 1 == TREE_L) begin
            e.at_endpoint = 1'b1;                    // leaves the router tree
            e.lk_port     = PORT_DOWN0;
        end else begin
            na        = set_digit(r.pos.addr, lv, cur);      // child
            e.lk_port = tree_port_e'(route_port(na, lv + 1, r.req.dest_addr));
        end
        oh = (TREE_K + 1)'(1) << cur;
        k  = 0;
        for (int b = 0; b <= TREE_K; b++) begin
            if (b != inp) begin
                e.port_req[k] = oh[b];
                k++;
            end
        end
        return e;
    endfunction

    // ======================================================================
    // stimulus table
    // ======================================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_row(input int addr, input int lv, input int dest,
                           input int inp, input int cur, input int gap);
        row_t r;
        r.pos.addr      = tree_addr_t'(addr);
        r.pos.level     = LW'(lv);
        r.req.dest_addr = tree_addr_t'(dest);
        r.req.in_port   = tree_port_e'(inp);
        r.req.cur_port  = tree_port_e'(cur);
        r.gap           = 2'(gap);
        table_rows[n_rows] = r;
        n_rows++;
    endtask

    task automatic build_table();
        logic [31:0] rng;
        int          lv;
        int          inp;
        int          cur;
        int          gap;
        n_rows = 0;
        add_row(3'b000, 0, 3'b110, 0, 1, 0);         // root, down
        add_row(3'b000, 0, 3'b011, 1, 0, 0);
        add_row(3'b001, 1, 3'b101, 2, 0, 1);         // middle, down
        add_row(3'b001, 1, 3'b010, 0, 2, 0);         // middle, up
        add_row(3'b011, 2, 3'b100, 2, 1, 0);         // leaf to endpoint
        add_row(3'b011, 2, 3'b000, 1, 2, 2);         // leaf, up
        add_row(3'b101, 2, 3'b111, 0, 2, 0);
        add_row(3'b010, 1, 3'b110, 1, 2, 0);
        add_row(3'b111, 2, 3'b011, 2, 0, 3);
        add_row(3'b000, 1, 3'b001, 2, 1, 0);
        rng = 32'h6dc75788;
        for (int n = 0; n < N_RAND; n++) begin
            rng = xorshift32(rng);
            lv  = int'(rng % TREE_L);
            inp = int'(rng[15:8] % (TREE_K + 1));
            gap = (rng[23:16] < 8'd48) ? int'(rng[25:24]) : 0;
            cur = inp;
            while (cur == inp || (lv == 0 && cur == UP_PORT)) begin
                rng = xorshift32(rng);
                cur = int'(rng % (TREE_K + 1));
            end
            rng = xorshift32(rng);
            add_row(int'(rng[ADDR_W-1:0]), lv, int'(rng[8 +: ADDR_W]), inp, cur, gap);
        end
        cycle_limit = RESET_CYCLES + 100;
        for (int n = 0; n < n_rows; n++)
            cycle_limit += 1 + int'(table_rows[n].gap);
    endtask

    // ======================================================================
    // drive and check
    // ======================================================================
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("** Error: %s got 0x%0h expected 0x%0h (cycle %0d)",
                     name, got, exp, cycle);
            errors++;
        end
    endtask

    // pos is read in the response cycle, so it trails req by one cycle
    task automatic drive_cycle(input logic v, input row_t r);
        exp_t e;
        @(posedge clk);
        #0.5;
        if (last_valid)
            pos = last_pos;
        req_valid = v;
        req       = v ? r.req : '0;
        if (v) begin
            e.rsp = model_rsp(r);
            e.due = 32'(cycle + 1);
            exp_q.push_back(e);
        end
        last_valid = v;
        last_pos   = r.pos;
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    always @(posedge clk) begin
        if (cycle >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    always @(negedge clk) begin
        exp_t e;
        if (!rst) begin
            if (rsp_valid) begin
                if (exp_q.size() == 0) begin
                    $display("response in cycle %0d with no request outstanding", cycle);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    if (e.due != 32'(cycle)) begin
                        $display("response in cycle %0d belongs to cycle %0d", cycle, e.due);
                        errors++;
                    end
                    check_value("rsp.port_req", 32'(rsp.port_req), 32'(e.rsp.port_req));
                    check_value("rsp.lk_port", 32'(rsp.lk_port), 32'(e.rsp.lk_port));
                    check_value("rsp.at_endpoint", 32'(rsp.at_endpoint),
                                32'(e.rsp.at_endpoint));
                end
            end else if (exp_q.size() != 0 && exp_q[0].due <= 32'(cycle)) begin
                $display("missing response, expected in cycle %0d", exp_q[0].due);
                errors++;
                void'(exp_q.pop_front());
            end
        end
    end

    initial begin
        row_t idle;
        rst        = 1'b1;
        pos        = '0;
        req_valid  = 1'b0;
        req        = '0;
        cycle      = 0;
        errors     = 0;
        checks     = 0;
        last_valid = 1'b0;
        last_pos   = '0;
        idle       = '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #0.5;
        rst = 1'b0;
        repeat (4) drive_cycle(1'b0, idle);          // quiet after reset
        for (int n = 0; n < n_rows; n++) begin
            drive_cycle(1'b1, table_rows[n]);
            repeat (table_rows[n].gap) drive_cycle(1'b0, idle);
        end
        repeat (2) drive_cycle(1'b0, idle);
        while (exp_q.size() != 0)
            @(negedge clk);
        repeat (3) @(negedge clk);
        $display("rows: %0d, checks: %0d, errors: %0d", n_rows, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tree_route_assertions.sv
`timescale 1ns/1ps
`default_nettype none

// strobe timing and request legality of the routing stage
module tree_route_assertions (
    input logic                       clk,
    input logic                       rst,
    input logic                       req_valid,
    input logic                       rsp_valid,
    input tree_route_pkg::route_req_t req_q,
    input tree_route_pkg::route_rsp_t rsp
);

    // ======================================================================
    // strobe timing
    // ======================================================================
    a_rsp_follows_req: assert property (
        @(posedge clk) disable iff (rst) req_valid |=> rsp_valid
    ) else $error("rsp_valid missing one cycle after req_valid");

    a_no_rsp_without_req: assert property (
        @(posedge clk) disable iff (rst) !req_valid |=> !rsp_valid
    ) else $error("rsp_valid without a request one cycle before");

    a_quiet_in_reset: assert property (
        @(posedge clk) rst |=> !rsp_valid            // cleared by the reset edge
    ) else $error("rsp_valid high during reset");

    // ======================================================================
    // response legality
    // ======================================================================
    // one request bit for a real turn, none when the header asks for a self-loop
    a_port_req_onehot0: assert property (
        @(posedge clk) disable iff (rst)
            rsp_valid |-> ((req_q.cur_port != req_q.in_port) ? $onehot(rsp.port_req)
                                                             : rsp.port_req == '0)
    ) else $error("port_req does not hold exactly the one requested port");

endmodule

`default_nettype wire

//--- tree_route_unit.sv
`timescale 1ns/1ps
`default_nettype none

// look-ahead routing stage of one tree router
module tree_route_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  tree_route_pkg::router_pos_t pos,         // held stable per test point
    input  logic                        req_valid,
    input  tree_route_pkg::route_req_t  req,
    output logic                        rsp_valid,
    output tree_route_pkg::route_rsp_t  rsp
);
    import tree_route_pkg::*;

    route_req_t req_q;                               // header after the register

    // ======================================================================
    // look-ahead and decode
    // ======================================================================
    tree_lookahead_route lookahead_i (
        .clk         (clk),
        .rst         (rst),
        .pos         (pos),
        .req_valid   (req_valid),
        .req         (req),
        .req_q       (req_q),
        .valid_q     (rsp_valid),
        .lk_port     (rsp.lk_port),
        .at_endpoint (rsp.at_endpoint)
    );

    tree_destport_gen destport_i (
        .cur_port (req_q.cur_port),
        .in_port  (req_q.in_port),
        .port_req (rsp.port_req)
    );

endmodule

`default_nettype wire

//--- tree_destport_gen.sv
`timescale 1ns/1ps
`default_nettype none

// chosen port to one-hot request for the switch allocator
module tree_destport_gen (
    input  tree_route_pkg::tree_port_e    cur_port,
    input  tree_route_pkg::tree_port_e    in_port,
    output logic [tree_route_pkg::TREE_K-1:0] port_req
);
    import tree_route_pkg::*;

    logic [TREE_K:0] onehot;                         // all K+1 ports

    // ======================================================================
    // decode
    // ======================================================================
    always_comb begin
        onehot           = '0;
        onehot[cur_port] = 1'b1;
    end

    // ======================================================================
    // drop input port bit
    // ======================================================================
    // no self-loops, so the arrival port never shows up as a request
    always_comb begin
        for (int j = 0; j < TREE_K; j++) begin
            if (j < int'(in_port)) begin
                port_req[j] = onehot[j];             // below in_port, keep place
            end else begin
                port_req[j] = onehot[j+1];           // above, shift down by one
            end
        end
    end

endmodule

`default_nettype wire

//--- tree_lookahead_route.sv
`timescale 1ns/1ps
`default_nettype none

// registers the header, then routes it one router ahead
module tree_lookahead_route (
    input  logic                        clk,
    input  logic                        rst,
    input  tree_route_pkg::router_pos_t pos,
    input  logic                        req_valid,
    input  tree_route_pkg::route_req_t  req,
    output tree_route_pkg::route_req_t  req_q,
    output logic                        valid_q,
    output tree_route_pkg::tree_port_e  lk_port,
    output logic                        at_endpoint
);
    import tree_route_pkg::*;

    router_pos_t next_pos;                           // router behind cur_port
    tree_port_e  nca_port;

    // ======================================================================
    // pipeline register
    // ======================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            req_q   <= '0;
        end else begin
            valid_q <= req_valid;                    // single-cycle strobe
            if (req_valid) begin
                req_q <= req;
            end
        end
    end

    // ======================================================================
    // next-hop prediction
    // ======================================================================
    tree_next_router_addr next_addr_i (
        .pos         (pos),
        .port        (req_q.cur_port),
        .next_pos    (next_pos),
        .at_endpoint (at_endpoint)
    );

    tree_nca_route nca_i (
        .pos       (next_pos),
        .dest_addr (req_q.dest_addr),
        .port      (nca_port)
    );

    // endpoint has a single link back, report it as down0
    assign lk_port = at_endpoint ? PORT_DOWN0 : nca_port;

endmodule

`default_nettype wire

//--- tree_next_router_addr.sv
`timescale 1ns/1ps
`default_nettype none

// position of the router reached through port, derived from own position
module tree_next_router_addr (
    input  tree_route_pkg::router_pos_t pos,
    input  tree_route_pkg::tree_port_e  port,
    output tree_route_pkg::router_pos_t next_pos,
    output logic                        at_endpoint
);
    import tree_route_pkg::*;

    logic [KW-1:0] port_digit;                       // down port as address digit
    logic          leaf_level;

    assign port_digit = KW'(port);
    assign leaf_level = (pos.level == LW'(TREE_L - 1));

    // ======================================================================
    // neighbor rule
    // ======================================================================
    always_comb begin
        next_pos    = pos;
        at_endpoint = 1'b0;
        if (port == PORT_UP) begin
            // parent drops the digit of our own level
            for (int i = 1; i < TREE_L; i++) begin
                if (int'(pos.level) == i) begin
                    next_pos.addr[(i-1)*KW +: KW] = '0;
                end
            end
            next_pos.level = pos.level - 1'b1;       // one step toward the root
        end else begin
            // child takes the port number as its digit
            for (int i = 0; i < TREE_L; i++) begin
                if (int'(pos.level) == i) begin
                    next_pos.addr[i*KW +: KW] = port_digit;
                end
            end
            next_pos.level = pos.level + 1'b1;
            at_endpoint    = leaf_level;             // below leaf is an endpoint
        end
    end

endmodule

`default_nettype wire

//--- tree_nca_route.sv
`timescale 1ns/1ps
`default_nettype none

// nearest-common-ancestor port choice for a router at pos
module tree_nca_route (
    input  tree_route_pkg::router_pos_t pos,
    input  tree_route_pkg::tree_addr_t  dest_addr,
    output tree_route_pkg::tree_port_e  port
);
    import tree_route_pkg::*;

    logic              mismatch;                     // some ancestor differs
    logic [KW-1:0]     down_digit;                   // dest digit at own level
    logic [PORT_W-1:0] down_port;

    // ======================================================================
    // ancestor compare
    // ======================================================================
    always_comb begin
        mismatch = 1'b0;
        for (int i = 1; i < TREE_L; i++) begin
            if (int'(pos.level) < i &&
                pos.addr[(i-1)*KW +: KW] != dest_addr[i*KW +: KW]) begin
                mismatch = 1'b1;                     // dest lies outside this subtree
            end
        end
    end

    // ======================================================================
    // down port select
    // ======================================================================
    always_comb begin
        down_digit = '0;
        for (int i = 0; i < TREE_L; i++) begin
            if (int'(pos.level) == i) begin
                down_digit = dest_addr[i*KW +: KW];
            end
        end
    end

    assign down_port = PORT_W'(down_digit);

    // up on any mismatch, else follow the dest digit
    assign port = mismatch ? PORT_UP : tree_port_e'(down_port);

endmodule

`default_nettype wire

//--- tree_route_pkg.sv
`default_nettype none

package tree_route_pkg;

    // ======================================================================
    // tree geometry
    // ======================================================================
    localparam int TREE_K  = 2;                      // down ports per router
    localparam int TREE_L  = 3;                      // router levels, 0 is root

    localparam int KW      = ($clog2(TREE_K) < 1) ? 1 : $clog2(TREE_K);
    localparam int LW      = $clog2(TREE_L + 1);     // level L marks the endpoint
    localparam int ADDR_W  = TREE_L * KW;
    localparam int PORT_W  = $clog2(TREE_K + 1);
    localparam int UP_PORT = TREE_K;                 // up port sits above the downs

    // ======================================================================
    // shared types
    // ======================================================================

    // digit i lives at bits [i*KW +: KW]
    typedef logic [ADDR_W-1:0] tree_addr_t;

    typedef enum logic [PORT_W-1:0] {
        PORT_DOWN0 = PORT_W'(0),
        PORT_DOWN1 = PORT_W'(1),
        PORT_UP    = PORT_W'(UP_PORT)
    } tree_port_e;

    typedef struct packed {
        tree_addr_t dest_addr;                       // final endpoint
        tree_port_e in_port;                         // arrival port
        tree_port_e cur_port;                        // picked by previous hop
    } route_req_t;

    typedef struct packed {
        logic [TREE_K-1:0] port_req;                 // one-hot, input port removed
        tree_port_e        lk_port;                  // port at the next router
        logic              at_endpoint;              // next hop leaves the tree
    } route_rsp_t;

    typedef struct packed {
        tree_addr_t    addr;
        logic [LW-1:0] level;
    } router_pos_t;

endpackage

`default_nettype wire
